// ==== flist.f ====
verilog/eg_pkg.sv
verilog/eg_ifs.sv
verilog/eg_delay_line.sv
verilog/eg_timebase.sv
verilog/eg_state_machine.sv
verilog/eg_rate_select.sv
verilog/eg_attn_update.sv
verilog/eg_level_scale.sv
verilog/eg_top.sv
tb/tb_clock.sv
tb/eg_checker.sv
tb/tb_eg_top.sv

// ==== tb/tb_eg_top.sv ====
`default_nettype none

module tb_eg_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        emuclk;
    logic        i_RST_n;
    logic [8:0]  i_FNUM;
    logic [2:0]  i_BLOCK;
    logic        i_KON, i_SUSEN, i_ETYP, i_AM, i_KSR, i_MNC_SEL;
    logic [5:0]  i_TL;
    logic [3:0]  i_AMVAL;
    logic [1:0]  i_KSL;
    logic [3:0]  i_AR, i_DR, i_RR, i_SL;
    logic [6:0]  o_OP_ATTNLV;
    logic        o_OP_ATTNLV_MAX;
    logic [3:0]  sus_lv;
    int unsigned seed = 32'hde99c7c2;

    tb_clock u_clock (.emuclk(emuclk), .o_RST_n(i_RST_n));

    eg_top DUT (.*);

    eg_checker u_checker (
        .emuclk          (emuclk),
        .i_FNUM          (i_FNUM),
        .i_BLOCK         (i_BLOCK),
        .i_KSL           (i_KSL),
        .i_TL            (i_TL),
        .i_AM            (i_AM),
        .i_AMVAL         (i_AMVAL),
        .i_OP_ATTNLV     (o_OP_ATTNLV),
        .i_OP_ATTNLV_MAX (o_OP_ATTNLV_MAX)
    );

    // Fastest release, then every slot silent for three frames
    task automatic key_off();
        @(posedge emuclk);
        i_KON     <= 1'b0;
        i_RR      <= 4'd15;
        i_SUSEN   <= 1'b0;
        i_MNC_SEL <= 1'b1; // Keeps the carrier key-off rate out
        u_checker.wait_silent(3, 20000);
    endtask

    initial begin
        void'($urandom(seed));
        i_FNUM    <= '0;
        i_BLOCK   <= '0;
        i_KON     <= 1'b0;
        i_SUSEN   <= 1'b0;
        i_ETYP    <= 1'b0;
        i_AM      <= 1'b0;
        i_KSR     <= 1'b0;
        i_MNC_SEL <= 1'b0;
        i_TL      <= '0;
        i_AMVAL   <= '0;
        i_KSL     <= '0;
        i_AR      <= '0;
        i_DR      <= '0;
        i_RR      <= '0;
        i_SL      <= '0;

        for (int n = 0; n < 100 && i_RST_n !== 1'b1; n++) begin
            @(posedge emuclk);
        end
        if (i_RST_n !== 1'b1) begin
            u_checker.timeouts++;
            $display("Timeout: reset was never released");
        end

        ////////////////////
        // Silent after reset
        u_checker.wait_silent(1, 200);
        u_checker.check_frames(127, 1'b1, 4);

        // Instant attack, level held at zero by a zero decay rate
        @(posedge emuclk);
        i_AR   <= 4'd15;
        i_DR   <= 4'd0;
        i_ETYP <= 1'b1;
        i_KON  <= 1'b1;
        repeat (6) begin
            @(posedge emuclk);
            i_KSL   <= 2'($urandom_range(3, 0));
            i_FNUM  <= 9'($urandom_range(511, 0));
            i_BLOCK <= 3'($urandom_range(7, 0));
            i_TL    <= 6'($urandom_range(47, 0));
            i_AM    <= 1'($urandom_range(1, 0));
            i_AMVAL <= 4'($urandom_range(15, 0));
            u_checker.wait_settled(2000);
            u_checker.check_frames(0, 1'b0, 2);
        end

        ////////////////////
        // Zero attack rate never leaves silence
        key_off();
        @(posedge emuclk);
        i_KSL <= '0;
        i_TL  <= '0;
        i_AM  <= 1'b0;
        i_AR  <= 4'd0;
        i_KON <= 1'b1;
        u_checker.check_frames(127, 1'b1, 20);

        // Decay down to the sustain level
        key_off();
        sus_lv = 4'($urandom_range(6, 1));
        @(posedge emuclk);
        i_AR    <= 4'd15;
        i_DR    <= 4'd8;
        i_ETYP  <= 1'b1;
        i_SL    <= sus_lv;
        i_FNUM  <= '0;
        i_BLOCK <= '0;
        i_KON   <= 1'b1;
        u_checker.wait_sustain(sus_lv, 600000);
        u_checker.check_hold(20);

        // Release back to silence
        key_off();
        u_checker.check_frames(127, 1'b1, 2);

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 u_checker.checks, u_checker.errors, u_checker.timeouts);
        if (u_checker.errors == 0 && u_checker.timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/eg_checker.sv ====
`default_nettype none

module eg_checker (
    input wire       emuclk,
    input wire [8:0] i_FNUM,
    input wire [2:0] i_BLOCK,
    input wire [1:0] i_KSL,
    input wire [5:0] i_TL,
    input wire       i_AM,
    input wire [3:0] i_AMVAL,
    input wire [6:0] i_OP_ATTNLV,
    input wire       i_OP_ATTNLV_MAX
);
    timeunit 1ns;
    timeprecision 1ps;

    // Key-scale base per FNUM[8:5], entry 0 in the low bits
    localparam logic [16*7-1:0] KEY_SCALE = {
        7'd64, 7'd63, 7'd62, 7'd61, 7'd60, 7'd59, 7'd58, 7'd56,
        7'd55, 7'd53, 7'd51, 7'd48, 7'd45, 7'd40, 7'd32, 7'd0
    };

    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    ////////////////////
    // Reference of the output stage
    function automatic logic [6:0] ref_level(input int base, input logic [1:0] ksl,
                                             input logic [8:0] fnum, input logic [2:0] block,
                                             input logic [5:0] tl, input logic am,
                                             input logic [3:0] amval);
        int ks;
        int total;
        ks = int'(KEY_SCALE[fnum[8:5]*7 +: 7]) + 8 * int'(block) - 64;
        if (ks < 0) begin
            ks = 0; // Below the scaling range
        end
        case (ksl)
            2'd0:    ks = 0;
            2'd1:    ks = ks / 2;
            2'd3:    ks = ks * 2;
            default: ks = ks;
        endcase
        total = base + ks + 2 * int'(tl) + (am ? int'(amval) : 0);
        return (total > 127) ? 7'd127 : 7'(total);
    endfunction

    task automatic compare_sample(input logic [6:0] exp_lv, input logic exp_max);
        checks++;
        if (i_OP_ATTNLV !== exp_lv) begin
            errors++;
            $display("ERROR o_OP_ATTNLV: got %h, expected %h at %0t", i_OP_ATTNLV, exp_lv, $time);
        end
        if (i_OP_ATTNLV_MAX !== exp_max) begin
            errors++;
            $display("ERROR o_OP_ATTNLV_MAX: got %h, expected %h at %0t",
                     i_OP_ATTNLV_MAX, exp_max, $time);
        end
    endtask

    // Every slot sample against the reference of one base level
    task automatic check_frames(input int base, input logic exp_max, input int frames);
        logic [6:0] exp_lv;
        repeat (frames * 18) begin
            @(negedge emuclk);
            exp_lv = ref_level(base, i_KSL, i_FNUM, i_BLOCK, i_TL, i_AM, i_AMVAL);
            compare_sample(exp_lv, exp_max);
        end
    endtask

    // Each slot must repeat its value of the first frame
    task automatic check_hold(input int frames);
        logic [6:0] prev [18];
        for (int i = 0; i < 18; i++) begin
            @(negedge emuclk);
            prev[i] = i_OP_ATTNLV;
        end
        repeat (frames) begin
            for (int i = 0; i < 18; i++) begin
                @(negedge emuclk);
                compare_sample(prev[i], 1'b0);
            end
        end
    endtask

    ////////////////////
    // Waits for a run of samples that meet one condition
    task automatic wait_run(input int kind, input logic [3:0] sl, input int run_len,
                            input int limit, input string what);
        logic [7:0] last;
        logic       hit;
        int         run;
        run = 0;
        last = 'x;
        for (int n = 0; n < limit && run < run_len; n++) begin
            @(negedge emuclk);
            case (kind)
                0:       hit = {i_OP_ATTNLV_MAX, i_OP_ATTNLV} === last; // No change
                1:       hit = i_OP_ATTNLV_MAX === 1'b1;
                default: hit = i_OP_ATTNLV[6:3] === sl;
            endcase
            run = hit ? run + 1 : 0;
            last = {i_OP_ATTNLV_MAX, i_OP_ATTNLV};
        end
        if (run < run_len) begin
            timeouts++;
            $display("Timeout: %s not seen within %0d cycles at %0t", what, limit, $time);
        end
    endtask

    task automatic wait_settled(input int limit);
        wait_run(0, 4'd0, 54, limit, "a settled output");
    endtask

    task automatic wait_silent(input int frames, input int limit);
        wait_run(1, 4'd0, frames * 18, limit, "the max flag on every slot");
    endtask

    task automatic wait_sustain(input logic [3:0] sl, input int limit);
        wait_run(2, sl, 18, limit, "the sustain level on every slot");
    endtask

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic emuclk,
    output logic o_RST_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        emuclk = 1'b0;
        forever #5 emuclk = ~emuclk; // 10 ns period
    end

    initial begin
        o_RST_n = 1'b0;
        repeat (5) @(posedge emuclk);
        o_RST_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/eg_top.sv ====
`default_nettype none

module eg_top (
    input  wire            emuclk,
    input  wire            i_RST_n,
    input  wire [8:0]      i_FNUM,
    input  wire [2:0]      i_BLOCK,
    input  wire            i_KON, i_SUSEN, i_ETYP, i_AM, i_KSR, i_MNC_SEL,
    input  wire [5:0]      i_TL,
    input  wire [3:0]      i_AMVAL,
    input  wire [1:0]      i_KSL,
    input  eg_pkg::rate_t  i_AR, i_DR, i_RR, i_SL,
    output eg_pkg::attn_t  o_OP_ATTNLV,
    output logic           o_OP_ATTNLV_MAX
);
    import eg_pkg::*;

    presc_t     presc;
    logic [1:0] envcntr;
    rate_t      attenrate;
    attn_t      attnlv_c18;

    eg_env_if  env ();
    eg_rate_if rate ();

    eg_timebase u_timebase (
        .emuclk      (emuclk),
        .i_RST_n     (i_RST_n),
        .o_CYCLE_00  (),
        .o_CYCLE_21  (),
        .o_PRESC     (presc),
        .o_ENVCNTR   (envcntr),
        .o_ATTENRATE (attenrate)
    );

    eg_state_machine u_state_machine (
        .emuclk  (emuclk),
        .i_RST_n (i_RST_n),
        .i_KON   (i_KON),
        .env     (env.sm)
    );

    eg_rate_select u_rate_select (
        .emuclk (emuclk),
        .i_KON (i_KON), .i_SUSEN (i_SUSEN), .i_ETYP (i_ETYP),
        .i_MNC_SEL (i_MNC_SEL), .i_KSR (i_KSR),
        .i_FNUM (i_FNUM), .i_BLOCK (i_BLOCK),
        .i_AR (i_AR), .i_DR (i_DR), .i_RR (i_RR),
        .i_PRESC (presc), .i_ENVCNTR (envcntr), .i_ATTENRATE (attenrate),
        .env (env.rs), .rate (rate.src)
    );

    eg_attn_update u_attn_update (
        .emuclk       (emuclk),
        .i_RST_n      (i_RST_n),
        .i_SL         (i_SL),
        .env          (env.au),
        .rate         (rate.dst),
        .o_ATTNLV_C18 (attnlv_c18),
        .o_ATTNLV_MAX (o_OP_ATTNLV_MAX)
    );

    eg_level_scale u_level_scale (
        .emuclk (emuclk),
        .i_FNUM (i_FNUM), .i_BLOCK (i_BLOCK), .i_KSL (i_KSL), .i_TL (i_TL),
        .i_AM (i_AM), .i_AMVAL (i_AMVAL),
        .i_ATTNLV    (attnlv_c18),
        .o_OP_ATTNLV (o_OP_ATTNLV)
    );

endmodule

`default_nettype wire

// ==== verilog/eg_level_scale.sv ====
`default_nettype none

module eg_level_scale (
    input  wire            emuclk,
    input  wire [8:0]      i_FNUM,
    input  wire [2:0]      i_BLOCK,
    input  wire [1:0]      i_KSL,
    input  wire [5:0]      i_TL,
    input  wire            i_AM,
    input  wire [3:0]      i_AMVAL,
    input  eg_pkg::attn_t  i_ATTNLV,
    output eg_pkg::attn_t  o_OP_ATTNLV
);
    import eg_pkg::*;

    logic [6:0] ks_base;
    logic [3:0] ks_hi;
    logic [5:0] ks_val;
    logic [6:0] ks_shifted;
    logic [7:0] ks_tl_c18;
    logic       am_c18;
    logic [7:0] ks_am;
    logic [7:0] scaled;

    assign ks_base = KS_TABLE[i_FNUM[8:5]];
    assign ks_hi   = {1'b0, ks_base[5:3]} + {1'b0, i_BLOCK};
    assign ks_val  = (ks_hi[3] | ks_base[6]) ? {ks_hi[2:0], ks_base[2:0]} : 6'd0;

    always_comb begin
        case (i_KSL)
            2'd0:    ks_shifted = 7'd0;
            2'd1:    ks_shifted = {2'b00, ks_val[5:1]}; // Half
            2'd2:    ks_shifted = {1'b0, ks_val};
            default: ks_shifted = {ks_val, 1'b0};       // Double
        endcase
    end

    always_ff @(posedge emuclk) begin
        ks_tl_c18 <= {1'b0, ks_shifted} + {1'b0, i_TL, 1'b0};
        am_c18    <= i_AM;
    end

    ////////////////////
    // AM, base level and saturation
    assign ks_am  = {1'b0, ks_tl_c18[6:0]} + {4'd0, am_c18 ? i_AMVAL : 4'd0};
    assign scaled = {1'b0, ks_am[6:0]} + {1'b0, i_ATTNLV};

    always_ff @(posedge emuclk) begin
        o_OP_ATTNLV <= (ks_tl_c18[7] | ks_am[7] | scaled[7]) ? ATTN_MAX : scaled[6:0];
    end

endmodule

`default_nettype wire

// ==== verilog/eg_attn_update.sv ====
`default_nettype none

module eg_attn_update (
    input  wire            emuclk,
    input  wire            i_RST_n,
    input  eg_pkg::rate_t  i_SL,
    eg_env_if.au           env,
    eg_rate_if.dst         rate,
    output eg_pkg::attn_t  o_ATTNLV_C18,
    output logic           o_ATTNLV_MAX
);
    import eg_pkg::*;

    logic [4:0] flush_cnt;  // Walks once around the ring after reset
    logic       flush;
    rate_t      rate_final;
    rate_t      sl_c18, sl_c19;
    logic       r12, r13, r14, r15, dw;
    logic       slow_atten, attn_act, dec_attnlv, force_max;
    logic [3:0] delta_sel;
    attn_t      attn_c2, attn_c17, attn_c19, attn_inv, delta, curr;

    assign flush = ~i_RST_n | (flush_cnt != 5'd0);

    always_ff @(posedge emuclk) begin
        if (!i_RST_n) begin
            flush_cnt <= NUM_SLOTS;
        end else if (flush_cnt != 5'd0) begin
            flush_cnt <= flush_cnt - 5'd1;
        end
    end

    ////////////////////
    // Cycle 2 delta selection
    assign r12 = rate.sat_rate == 4'd12;
    assign r13 = rate.sat_rate == 4'd13;
    assign r14 = rate.sat_rate == 4'd14;
    assign r15 = rate.sat_rate == FASTEST_RATE;
    assign dw  = rate.dw_intensity;
    assign rate_final = rate.sat_rate + rate.atten_rate; // Carry dropped

    assign slow_atten = (rate.sat_rate < 4'd12) & ~rate.rate_zero &
                        ((rate_final == 4'd12) |
                         ((rate_final == 4'd13) & rate.ksr_lo[1]) |
                         ((rate_final == 4'd14) & rate.ksr_lo[0]));

    // Linear step in decay, sustain and release
    assign attn_act = ~env.quiet_c19 & ~env.start_attack_c19 &
                      (env.envstat_c19[1] | ((env.envstat_c19 == DECAY) & ~env.decay_end));

    assign delta_sel[0] = slow_atten | (r12 & ~dw);
    assign delta_sel[1] = (r12 & dw) | (r13 & ~dw);
    assign delta_sel[2] = (r13 & dw) | (r14 & ~dw) |
                          (attn_act & ((r12 & (rate.presc == 2'd3) & ~dw) |
                                       (r12 & rate.presc[0] & dw) |
                                       (r13 & rate.presc[0] & ~dw) |
                                       (slow_atten & (rate.presc == 2'd3))));
    assign delta_sel[3] = (r14 & dw) | r15;

    // Attack moves by a fraction of the inverted level
    assign dec_attnlv = (env.envstat_c19 == ATTACK) & env.kon_c19 & ~r15 & ~env.attnlv_min;
    assign attn_inv   = dec_attnlv ? ~attn_c19 : 7'd0;

    assign delta = ({7{delta_sel[0]}} & {{4{dec_attnlv}}, attn_inv[6:4]}) |
                   ({7{delta_sel[1]}} & {{3{dec_attnlv}}, attn_inv[6:3]}) |
                   ({7{delta_sel[2]}} & {{2{dec_attnlv}}, attn_inv[6:3],
                                         attn_act | attn_inv[2]}) |
                   ({7{delta_sel[3]}} & {dec_attnlv, attn_inv[6:3],
                                         attn_act | attn_inv[2], attn_inv[1]});

    assign force_max = env.quiet_c19 & (env.envstat_c19 != ATTACK) & ~env.start_attack_c19;
    assign curr = force_max ? ATTN_MAX : ((r15 & env.start_attack_c19) ? 7'd0 : attn_c19);

    ////////////////////
    // Storage ring
    always_ff @(posedge emuclk) begin
        attn_c2      <= flush ? ATTN_MAX : curr + delta;
        o_ATTNLV_C18 <= attn_c17;
        sl_c18       <= i_SL;
        sl_c19       <= sl_c18;
    end

    eg_delay_line #(.WIDTH(7), .LENGTH(17), .TAP(15)) u_attn_ring (
        .emuclk   (emuclk),
        .i_D      (attn_c2),
        .o_Q_TAP  (attn_c17),
        .o_Q_LAST (attn_c19)
    );

    assign env.quiet_c18  = &attn_c17[6:2];
    assign env.quiet_c19  = &attn_c19[6:2];
    assign env.attnlv_min = attn_c19 == 7'd0;
    assign env.decay_end  = attn_c19[6:3] == sl_c19;
    assign o_ATTNLV_MAX   = attn_c19 == ATTN_MAX;

endmodule

`default_nettype wire

// ==== verilog/eg_rate_select.sv ====
`default_nettype none

module eg_rate_select (
    input  wire             emuclk,
    input  wire             i_KON, i_SUSEN, i_ETYP, i_MNC_SEL, i_KSR,
    input  wire [8:0]       i_FNUM,
    input  wire [2:0]       i_BLOCK,
    input  eg_pkg::rate_t   i_AR, i_DR, i_RR,
    input  eg_pkg::presc_t  i_PRESC,
    input  wire [1:0]       i_ENVCNTR,
    input  eg_pkg::rate_t   i_ATTENRATE,
    eg_env_if.rs            env,
    eg_rate_if.src          rate
);
    import eg_pkg::*;

    logic [1:0] sel;
    envstat_e   stat_masked;
    rate_t      rate_c0;
    ksr_t       ksr_c0;
    logic [4:0] rate_scaled;

    // Damp on a pending restart, quick release for a keyed-off carrier
    assign sel = {i_KON & (env.envstat_c17 == RELEASE) & ~env.quiet_c18,
                  ~i_KON & ~i_SUSEN & ~i_MNC_SEL & ~i_ETYP};
    assign stat_masked = env.start_attack_c18 ? ATTACK : env.envstat_c17;

    ////////////////////
    // Cycle 0 rate mux
    always_ff @(posedge emuclk) begin
        case (sel)
            2'b10: rate_c0 <= DAMP_RATE;
            2'b01: rate_c0 <= CARRIER_OFF_RATE;
            default: begin
                case (stat_masked)
                    ATTACK:  rate_c0 <= i_AR;
                    DECAY:   rate_c0 <= i_DR;
                    SUSTAIN: rate_c0 <= i_ETYP ? 4'd0 : i_RR; // Sustained type holds
                    default: rate_c0 <= i_SUSEN ? SUSTAIN_OFF_RATE : i_RR;
                endcase
            end
        endcase
        ksr_c0 <= i_KSR ? {i_BLOCK, i_FNUM[8]} : {2'b00, i_BLOCK[2:1]};
    end

    ////////////////////
    // Cycle 1 scaling
    assign rate_scaled = {1'b0, rate_c0} + {3'b000, ksr_c0[3:2]};

    always_ff @(posedge emuclk) begin
        rate.sat_rate     <= rate_scaled[4] ? FASTEST_RATE : rate_scaled[3:0];
        rate.atten_rate   <= i_ATTENRATE;
        rate.presc        <= i_PRESC;
        rate.ksr_lo       <= ksr_c0[1:0];
        rate.rate_zero    <= rate_c0 == 4'd0;
        rate.dw_intensity <= (ksr_c0[1] & ~i_ENVCNTR[0]) |
                             (ksr_c0[0] & (i_ENVCNTR == 2'd0)) |
                             ((ksr_c0 == 4'd3) & (i_ENVCNTR == 2'd1));
    end

endmodule

`default_nettype wire

// ==== verilog/eg_state_machine.sv ====
`default_nettype none

module eg_state_machine (
    input  wire   emuclk,
    input  wire   i_RST_n,
    input  wire   i_KON,
    eg_env_if.sm  env
);
    import eg_pkg::*;

    envstat_e   next_stat;
    logic [1:0] stat_c17;
    logic [1:0] stat_c19;
    logic       kon_c18;
    logic       start_c18r;

    // State ring, written at cycle 2
    eg_delay_line #(.WIDTH(2), .LENGTH(18), .TAP(16)) u_stat_ring (
        .emuclk   (emuclk),
        .i_D      (next_stat),
        .o_Q_TAP  (stat_c17),
        .o_Q_LAST (stat_c19)
    );

    assign env.envstat_c17 = envstat_e'(stat_c17);
    assign env.envstat_c19 = envstat_e'(stat_c19);

    // Restart only once the previous envelope has died out
    assign env.start_attack_c18 = (env.envstat_c17 == RELEASE) & env.quiet_c18 & i_KON;

    always_ff @(posedge emuclk) begin
        if (!i_RST_n) begin
            kon_c18              <= 1'b0;
            env.kon_c19          <= 1'b0;
            start_c18r           <= 1'b0;
            env.start_attack_c19 <= 1'b0;
        end else begin
            kon_c18              <= i_KON;
            env.kon_c19          <= kon_c18;
            start_c18r           <= env.start_attack_c18;
            env.start_attack_c19 <= start_c18r;
        end
    end

    ////////////////////
    // Next state
    always_comb begin
        if (!i_RST_n || (!env.start_attack_c19 && !env.kon_c19)) begin
            next_stat = RELEASE;
        end else if (env.start_attack_c19) begin
            next_stat = ATTACK;
        end else begin
            case (env.envstat_c19)
                ATTACK:  next_stat = env.attnlv_min ? DECAY : ATTACK;
                DECAY:   next_stat = env.decay_end ? SUSTAIN : DECAY;
                SUSTAIN: next_stat = SUSTAIN;
                default: next_stat = RELEASE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eg_timebase.sv ====
`default_nettype none

module eg_timebase (
    input  wire             emuclk,
    input  wire             i_RST_n,
    output logic            o_CYCLE_00,
    output logic            o_CYCLE_21,
    output eg_pkg::presc_t  o_PRESC,
    output logic [1:0]      o_ENVCNTR,
    output eg_pkg::rate_t   o_ATTENRATE
);
    import eg_pkg::*;

    logic [4:0]  slot;
    logic        presc_d0;
    logic [17:0] cntr_sr;   // Envelope counter, LSB leaves first
    logic        cntr_co;
    logic [1:0]  cntr_add;
    logic        det_one;
    logic [16:0] zb_sr;     // Marks the first set bit of the counter
    logic        latch;

    assign o_CYCLE_00 = slot == 5'd0;
    assign o_CYCLE_21 = slot == NUM_SLOTS - 5'd1; // Last slot of a frame

    // Carry injected at the LSB once every four frames
    assign cntr_add = {1'b0, (cntr_co | o_CYCLE_00) & (o_PRESC == 2'd3)} + {1'b0, cntr_sr[0]};
    assign latch    = o_CYCLE_00 & presc_d0;

    ////////////////////
    // Slot counter, prescaler and serial counter
    always_ff @(posedge emuclk) begin
        if (!i_RST_n) begin
            slot        <= 5'd0;
            o_PRESC     <= 2'd0;
            presc_d0    <= 1'b0;
            cntr_sr     <= '0;
            cntr_co     <= 1'b0;
            det_one     <= 1'b0;
            zb_sr       <= '0;
            o_ENVCNTR   <= 2'd0;
            o_ATTENRATE <= 4'd0;
        end else begin
            slot     <= o_CYCLE_21 ? 5'd0 : slot + 5'd1;
            o_PRESC  <= o_CYCLE_21 ? o_PRESC + 2'd1 : o_PRESC;
            presc_d0 <= o_PRESC[0];
            cntr_co  <= cntr_add[1];
            cntr_sr  <= {cntr_add[0], cntr_sr[17:1]};
            det_one  <= o_CYCLE_00 | (det_one & ~cntr_sr[17]); // Armed until first one
            zb_sr    <= {det_one & cntr_sr[17], zb_sr[16:1]};

            // Trailing zero count plus one, latched every other frame
            if (latch) begin
                o_ENVCNTR      <= cntr_sr[1:0];
                o_ATTENRATE[3] <= |zb_sr[12:7];
                o_ATTENRATE[2] <= |{zb_sr[12:11], zb_sr[6:3]};
                o_ATTENRATE[1] <= |{zb_sr[10:9], zb_sr[6:5], zb_sr[2:1]};
                o_ATTENRATE[0] <= |{zb_sr[12], zb_sr[10], zb_sr[8], zb_sr[6],
                                    zb_sr[4], zb_sr[2], zb_sr[0]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eg_delay_line.sv ====
`default_nettype none

module eg_delay_line #(
    parameter int WIDTH  = 1,
    parameter int LENGTH = 2,
    parameter int TAP    = 1   // Stages up to the mid tap
) (
    input  wire              emuclk,
    input  wire [WIDTH-1:0]  i_D,
    output logic [WIDTH-1:0] o_Q_TAP,
    output logic [WIDTH-1:0] o_Q_LAST
);

    logic [WIDTH-1:0] sr [1:LENGTH];

    always_ff @(posedge emuclk) begin
        sr[1] <= i_D;
        for (int i = 2; i <= LENGTH; i++) begin
            sr[i] <= sr[i-1];
        end
    end

    assign o_Q_TAP  = sr[TAP];
    assign o_Q_LAST = sr[LENGTH];

endmodule

`default_nettype wire

// ==== verilog/eg_ifs.sv ====
`default_nettype none

interface eg_env_if;
    import eg_pkg::*;

    envstat_e envstat_c17;
    envstat_e envstat_c19;
    logic     start_attack_c18;
    logic     start_attack_c19;
    logic     kon_c19;

    logic     quiet_c18;   // Level close to silence
    logic     quiet_c19;
    logic     decay_end;   // Top bits of level reached SL
    logic     attnlv_min;

    modport sm (
        output envstat_c17, envstat_c19, start_attack_c18, start_attack_c19, kon_c19,
        input  quiet_c18, decay_end, attnlv_min
    );

    modport au (
        output quiet_c18, quiet_c19, decay_end, attnlv_min,
        input  envstat_c19, start_attack_c19, kon_c19
    );

    modport rs (
        input envstat_c17, start_attack_c18, quiet_c18
    );
endinterface

interface eg_rate_if;
    import eg_pkg::*;

    rate_t      sat_rate;     // Rate after KSR scaling
    rate_t      atten_rate;   // Zero-bit rate count
    logic       dw_intensity;
    logic [1:0] ksr_lo;
    logic       rate_zero;
    presc_t     presc;

    modport src (output sat_rate, atten_rate, dw_intensity, ksr_lo, rate_zero, presc);
    modport dst (input  sat_rate, atten_rate, dw_intensity, ksr_lo, rate_zero, presc);
endinterface

`default_nettype wire

// ==== verilog/eg_pkg.sv ====
`default_nettype none

package eg_pkg;

    localparam logic [4:0] NUM_SLOTS = 5'd18; // Operator slots per frame

    typedef logic [6:0] attn_t;  // 0.375 dB per step
    typedef logic [3:0] rate_t;
    typedef logic [3:0] ksr_t;
    typedef logic [1:0] presc_t;

    typedef enum logic [1:0] {
        ATTACK  = 2'd0,
        DECAY   = 2'd1,
        SUSTAIN = 2'd2,
        RELEASE = 2'd3
    } envstat_e;

    localparam attn_t ATTN_MAX = 7'd127; // Silent

    ////////////////////
    // Rates forced by the rate mux
    localparam rate_t DAMP_RATE        = 4'd12; // Damps the old envelope before a new attack
    localparam rate_t CARRIER_OFF_RATE = 4'd7;
    localparam rate_t SUSTAIN_OFF_RATE = 4'd5;
    localparam rate_t FASTEST_RATE     = 4'd15;

    // Key-scale base level, indexed by FNUM[8:5]
    localparam logic [6:0] KS_TABLE [16] = '{
        7'd0,  7'd32, 7'd40, 7'd45, 7'd48, 7'd51, 7'd53, 7'd55,
        7'd56, 7'd58, 7'd59, 7'd60, 7'd61, 7'd62, 7'd63, 7'd64
    };

endpackage

`default_nettype wire
